//--- Makefile
TOP = tbGpioSubsystem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	rm -f sim.log
	verilator --binary --timing --assert -sv -f compile.f --top-module $(TOP) \
		-Mdir obj_dir -o simv
	./obj_dir/simv | tee sim.log
	@if grep -q "^Result: PASSED" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

//--- compile.f
+incdir+hdl
hdl/gpioBridgePkg.sv
hdl/ahbApbBridge.sv
hdl/apbGpio.sv
hdl/gpioSubsystem.sv
verif/tbGpioSubsystem.sv

//--- hdl/ahbApbBridge.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpioBridge_defs.svh"

module ahbApbBridge
    import gpioBridgePkg::*;
(
    input  wire         iHCLK,
    input  wire         iHRESETn,
    input  wire         hSel,
    input  wire  [1:0]  hTrans,
    input  wire         hWrite,
    input  wire  [31:0] hAddr,
    input  wire  [31:0] hWdata,
    input  wire  [31:0] prdata0,
    input  wire  [31:0] prdata1,
    output logic        hReady,
    output logic [31:0] hRdata,
    output apbReqT      apbReq
);

    localparam logic [31:0] Gpio0Base = `GPIO0_BASE;
    localparam logic [31:0] Gpio1Base = `GPIO1_BASE;

    bridgeStateT state;
    bridgeStateT stateNext;
    logic        accept;
    logic        writeReg;
    logic [31:0] addrReg;
    logic [31:0] wdataReg;
    logic [1:0]  regionSel;
    logic [1:0]  sel;

    // Only SETUP stalls the master
    assign hReady = (state != SETUP);

    // NONSEQ or SEQ; BUSY and IDLE fall through as no transfer
    assign accept = hSel && hTrans[1] && hReady;

    always_comb begin
        case (state)
            IDLE:    stateNext = accept ? SETUP : IDLE;
            SETUP:   stateNext = ENABLE;
            ENABLE:  stateNext = accept ? SETUP : IDLE;
            default: stateNext = IDLE;
        endcase
    end

    always_ff @(posedge iHCLK) begin
        if (!iHRESETn) begin
            state <= IDLE;
        end else begin
            state <= stateNext;
        end
    end

    // Address phase capture
    always_ff @(posedge iHCLK) begin
        if (!iHRESETn) begin
            writeReg <= 1'b0;
        end else if (accept) begin
            writeReg <= hWrite;
        end
    end

    always_ff @(posedge iHCLK) begin
        if (accept) begin
            addrReg <= hAddr;
        end
    end

    // AHB write data is valid during SETUP, hold it for ENABLE
    always_ff @(posedge iHCLK) begin
        if (state == SETUP) begin
            wdataReg <= hWdata;
        end
    end

    // Region decode on the upper address bits
    always_comb begin
        regionSel[0] = (addrReg[`REGION_MSB:`REGION_LSB] ==
                        Gpio0Base[`REGION_MSB:`REGION_LSB]);
        regionSel[1] = (addrReg[`REGION_MSB:`REGION_LSB] ==
                        Gpio1Base[`REGION_MSB:`REGION_LSB]);
    end

    assign sel = (state == IDLE) ? 2'b00 : regionSel;

    // Unmapped accesses run no APB cycle at all
    always_comb begin
        apbReq.sel    = sel;
        apbReq.enable = (state == ENABLE) && (sel != 2'b00);
        apbReq.write  = writeReg;
        apbReq.addr   = addrReg;
        apbReq.wdata  = (state == SETUP) ? hWdata : wdataReg;
    end

    // Slaves drive zero when idle, so unmapped reads come back as zero
    always_comb begin
        case (sel)
            2'b01:   hRdata = prdata0;
            2'b10:   hRdata = prdata1;
            default: hRdata = 32'h0000_0000;
        endcase
    end

    // APB enable must follow a setup cycle to the same slave
    apbEnableAfterSetup: assert property (
        @(posedge iHCLK) disable iff (!iHRESETn)
        apbReq.enable |-> ($past(state) == SETUP) && $stable(apbReq.sel)
    ) else $error("APB enable without matching setup");

    // Zero-wait APB slaves, so at most one stall cycle
    hReadySingleStall: assert property (
        @(posedge iHCLK) disable iff (!iHRESETn)
        !hReady |=> hReady
    ) else $error("hReady low for two cycles");

endmodule

`default_nettype wire

//--- hdl/apbGpio.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpioBridge_defs.svh"

module apbGpio
    import gpioBridgePkg::*;
#(
    parameter int PORT_IDX = 0
) (
    input  wire                    iHCLK,
    input  wire                    iHRESETn,
    input  wire apbReqT            apbReq,
    input  wire [`GPIO_WIDTH-1:0]  gpioIn,
    output logic [31:0]            prdata,
    output gpioPadT                pads
);

    logic                   selected;
    logic                   wrStrobe;
    logic [1:0]             regOff;
    logic [`GPIO_WIDTH-1:0] syncMeta;
    logic [`GPIO_WIDTH-1:0] dinReg;

    assign selected = apbReq.sel[PORT_IDX];
    assign regOff   = apbReq.addr[3:2];

    // Slave commits at the edge that closes the enable cycle
    assign wrStrobe = selected && apbReq.enable && apbReq.write;

    always_ff @(posedge iHCLK) begin
        if (!iHRESETn) begin
            pads <= '0;
        end else if (wrStrobe) begin
            case (regOff)
                `REG_DOUT: pads.dout <= apbReq.wdata[`GPIO_WIDTH-1:0];
                `REG_DIR:  pads.oe   <= apbReq.wdata[`GPIO_WIDTH-1:0];
                default: ;
            endcase
        end
    end

    // Two-flop synchronizer on the input pins
    always_ff @(posedge iHCLK) begin
        if (!iHRESETn) begin
            syncMeta <= '0;
            dinReg   <= '0;
        end else begin
            syncMeta <= gpioIn;
            dinReg   <= syncMeta;
        end
    end

    // Zero when not selected keeps the bridge mux a plain select
    always_comb begin
        prdata = 32'h0000_0000;
        if (selected) begin
            case (regOff)
                `REG_DOUT: prdata[`GPIO_WIDTH-1:0] = pads.dout;
                `REG_DIR:  prdata[`GPIO_WIDTH-1:0] = pads.oe;
                `REG_DIN:  prdata[`GPIO_WIDTH-1:0] = dinReg;
                default:   prdata = 32'h0000_0000;
            endcase
        end
    end

    // Enable only travels with a live select
    apbEnableNeedsSel: assert property (
        @(posedge iHCLK) disable iff (!iHRESETn)
        apbReq.enable |-> (apbReq.sel != 2'b00)
    ) else $error("APB enable with no select at port %0d", PORT_IDX);

endmodule

`default_nettype wire

//--- hdl/gpioBridgePkg.sv
`default_nettype none

`include "gpioBridge_defs.svh"

package gpioBridgePkg;

    // APB request, broadcast from the bridge to every slave
    typedef struct packed {
        logic [1:0]  sel;
        logic        enable;
        logic        write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } apbReqT;

    // Pad drive of one GPIO port
    typedef struct packed {
        logic [`GPIO_WIDTH-1:0] dout;
        logic [`GPIO_WIDTH-1:0] oe;
    } gpioPadT;

    // Bridge FSM
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        SETUP  = 2'b01,
        ENABLE = 2'b10
    } bridgeStateT;

endpackage

`default_nettype wire

//--- hdl/gpioBridge_defs.svh
`ifndef GPIO_BRIDGE_DEFS_SVH
`define GPIO_BRIDGE_DEFS_SVH

// Pins per GPIO port
`define GPIO_WIDTH 16

// Region bases on the AHB map
`define GPIO0_BASE 32'h0000_0000
`define GPIO1_BASE 32'h0000_8000

// Address bits that pick a region
`define REGION_MSB 31
`define REGION_LSB 15

// Register word offsets, decoded on address bits 3..2
`define REG_DOUT 2'd0
`define REG_DIR  2'd1
`define REG_DIN  2'd2

`endif

//--- hdl/gpioSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpioBridge_defs.svh"

module gpioSubsystem
    import gpioBridgePkg::*;
(
    input  wire                    iHCLK,
    input  wire                    iHRESETn,
    input  wire                    hSel,
    input  wire [1:0]              hTrans,
    input  wire                    hWrite,
    input  wire [31:0]             hAddr,
    input  wire [31:0]             hWdata,
    input  wire [`GPIO_WIDTH-1:0]  gpioIn0,
    input  wire [`GPIO_WIDTH-1:0]  gpioIn1,
    output logic                   hReady,
    output logic [31:0]            hRdata,
    output gpioPadT                pads0,
    output gpioPadT                pads1
);

    apbReqT      apbReq;
    logic [31:0] prdata0;
    logic [31:0] prdata1;

    ahbApbBridge u_ahbApbBridge (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .hSel     (hSel),
        .hTrans   (hTrans),
        .hWrite   (hWrite),
        .hAddr    (hAddr),
        .hWdata   (hWdata),
        .prdata0  (prdata0),
        .prdata1  (prdata1),
        .hReady   (hReady),
        .hRdata   (hRdata),
        .apbReq   (apbReq)
    );

    // Port 0 at the low region
    apbGpio #(.PORT_IDX(0)) u_apbGpio0 (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .apbReq   (apbReq),
        .gpioIn   (gpioIn0),
        .prdata   (prdata0),
        .pads     (pads0)
    );

    apbGpio #(.PORT_IDX(1)) u_apbGpio1 (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .apbReq   (apbReq),
        .gpioIn   (gpioIn1),
        .prdata   (prdata1),
        .pads     (pads1)
    );

endmodule

`default_nettype wire

//--- verif/tbGpioSubsystem.sv
`timescale 1ns/1ns
`default_nettype none

`include "gpioBridge_defs.svh"

module tbGpioSubsystem
    import gpioBridgePkg::*;
;

    localparam int NumRandom     = 150;
    localparam int NumDirected   = 22;
    localparam int TimeoutCycles = (NumRandom + NumDirected) * 4 + 200;

    logic                   iHCLK;
    logic                   iHRESETn;
    logic                   hSel;
    logic [1:0]             hTrans;
    logic                   hWrite;
    logic [31:0]            hAddr;
    logic [31:0]            hWdata;
    logic [`GPIO_WIDTH-1:0] gpioIn0;
    logic [`GPIO_WIDTH-1:0] gpioIn1;
    wire                    hReady;
    wire  [31:0]            hRdata;
    gpioPadT                pads0;
    gpioPadT                pads1;

    // Reference model, one entry per port
    logic [`GPIO_WIDTH-1:0] modelDout [2];
    logic [`GPIO_WIDTH-1:0] modelDir [2];
    logic [`GPIO_WIDTH-1:0] modelDin [2];

    // Transfer sitting in its data phase
    logic        pendValid;
    logic        pendWrite;
    logic [31:0] pendAddr;
    logic [31:0] pendData;

    integer seed;
    int     cycleCount = 0;
    int     checkCount = 0;
    int     errorCount = 0;
    int     testCount = 0;
    int     errorsAtStart = 0;

    gpioSubsystem u_gpioSubsystem (
        .iHCLK    (iHCLK),
        .iHRESETn (iHRESETn),
        .hSel     (hSel),
        .hTrans   (hTrans),
        .hWrite   (hWrite),
        .hAddr    (hAddr),
        .hWdata   (hWdata),
        .gpioIn0  (gpioIn0),
        .gpioIn1  (gpioIn1),
        .hReady   (hReady),
        .hRdata   (hRdata),
        .pads0    (pads0),
        .pads1    (pads1)
    );

    always #50 iHCLK = ~iHCLK;

    always @(posedge iHCLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount = checkCount + 1;
        if (actual !== expected) begin
            errorCount = errorCount + 1;
            $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // Port index from the region map, -1 when unmapped
    function automatic int portOf(input logic [31:0] addr);
        if ((addr & 32'hFFFF_8000) == `GPIO0_BASE) return 0;
        if ((addr & 32'hFFFF_8000) == `GPIO1_BASE) return 1;
        return -1;
    endfunction

    function automatic logic [31:0] expectRead(input logic [31:0] addr);
        int p;
        p = portOf(addr);
        if (p < 0) return 32'h0;
        case (addr[3:2])
            2'd0:    return 32'(modelDout[p]);
            2'd1:    return 32'(modelDir[p]);
            2'd2:    return 32'(modelDin[p]);
            default: return 32'h0;
        endcase
    endfunction

    task automatic modelWrite(input logic [31:0] addr, input logic [31:0] data);
        int p;
        p = portOf(addr);
        if (p >= 0 && addr[3:2] == 2'd0) modelDout[p] = data[`GPIO_WIDTH-1:0];
        if (p >= 0 && addr[3:2] == 2'd1) modelDir[p] = data[`GPIO_WIDTH-1:0];
    endtask

    // Ends the cycle: checks the data phase, then retires it at the edge
    task automatic completePending();
        @(negedge iHCLK);
        checkValue("hReady", 32'd1, 32'(hReady));
        checkValue("pads0", {modelDout[0], modelDir[0]}, pads0);
        checkValue("pads1", {modelDout[1], modelDir[1]}, pads1);
        if (pendValid && !pendWrite) checkValue("hRdata", expectRead(pendAddr), hRdata);
        @(posedge iHCLK);
        if (pendValid && pendWrite) modelWrite(pendAddr, pendData);
        pendValid = 1'b0;
    endtask

    task automatic driveIdle();
        hSel   = 1'b0;
        hTrans = 2'b00;
        hWrite = 1'b0;
        completePending();
        #1;
    endtask

    // Address phase now, SETUP next; returns in ENABLE, so the next call is back-to-back
    task automatic doTransfer(input logic wr, input logic [31:0] addr,
                              input logic [31:0] wdata);
        hSel   = 1'b1;
        hTrans = 2'b10;
        hWrite = wr;
        hAddr  = addr;
        completePending();
        #1;
        hSel   = 1'b0;
        hTrans = 2'b00;
        hWrite = 1'b0;
        hWdata = wdata;
        @(negedge iHCLK);
        checkValue("hReady", 32'd0, 32'(hReady));
        @(posedge iHCLK);
        #1;
        pendValid = 1'b1;
        pendWrite = wr;
        pendAddr  = addr;
        pendData  = wdata;
    endtask

    // New pin values, then enough idle cycles for the synchronizer
    task automatic settleInputs();
        driveIdle();
        gpioIn0 = `GPIO_WIDTH'($random(seed));
        gpioIn1 = `GPIO_WIDTH'($random(seed));
        repeat (4) driveIdle();
        modelDin[0] = gpioIn0;
        modelDin[1] = gpioIn1;
    endtask

    task automatic pickAddr(output logic [31:0] addr);
        int kind;
        kind = {$random(seed)} % 8;
        if (kind == 0) begin
            addr = 32'($random(seed)) | 32'h0001_0000;
        end else begin
            addr = (kind[0] ? `GPIO1_BASE : `GPIO0_BASE) | 32'({$random(seed)} % 4 * 4);
        end
    endtask

    task automatic startTest();
        errorsAtStart = errorCount;
        testCount = testCount + 1;
    endtask

    task automatic reportTest(input string name);
        $display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsAtStart);
    endtask

    initial begin
        logic [31:0] base;
        logic [31:0] addr;
        int          gap;
        seed = 32'hc768_c812;
        iHCLK = 1'b0;
        iHRESETn = 1'b0;
        hSel = 1'b0;
        hTrans = 2'b00;
        hWrite = 1'b0;
        hAddr = 32'h0;
        hWdata = 32'h0;
        gpioIn0 = '0;
        gpioIn1 = '0;
        pendValid = 1'b0;
        pendWrite = 1'b0;
        pendAddr = 32'h0;
        pendData = 32'h0;
        for (int p = 0; p < 2; p++) begin
            modelDout[p] = '0;
            modelDir[p] = '0;
            modelDin[p] = '0;
        end
        repeat (5) @(posedge iHCLK);
        #1;
        iHRESETn = 1'b1;

        startTest();
        driveIdle();
        reportTest("reset state");

        startTest();
        for (int p = 0; p < 2; p++) begin
            base = (p == 0) ? `GPIO0_BASE : `GPIO1_BASE;
            doTransfer(1'b1, base, 32'($random(seed)));
            doTransfer(1'b1, base + 32'd4, 32'($random(seed)));
            doTransfer(1'b0, base, 32'h0);
            doTransfer(1'b0, base + 32'd4, 32'h0);
            driveIdle();
        end
        reportTest("output and direction registers");

        startTest();
        settleInputs();
        for (int p = 0; p < 2; p++) begin
            base = (p == 0) ? `GPIO0_BASE : `GPIO1_BASE;
            doTransfer(1'b0, base + 32'd8, 32'h0);
            doTransfer(1'b1, base + 32'd8, 32'($random(seed)));
            doTransfer(1'b0, base + 32'd8, 32'h0);
        end
        driveIdle();
        reportTest("input register");

        startTest();
        repeat (4) begin
            addr = 32'($random(seed)) | 32'h0001_0000;
            doTransfer(1'b1, addr, 32'($random(seed)));
            doTransfer(1'b0, addr, 32'h0);
        end
        driveIdle();
        reportTest("unmapped addresses");

        // Gaps of zero give back-to-back runs
        startTest();
        for (int i = 0; i < NumRandom; i++) begin
            pickAddr(addr);
            doTransfer(1'($random(seed)), addr, 32'($random(seed)));
            gap = {$random(seed)} % 3;
            repeat (gap) driveIdle();
            if (i % 50 == 49) settleInputs();
        end
        driveIdle();
        reportTest("random mix");

        $display("Checks: %0d, errors: %0d, tests: %0d", checkCount, errorCount, testCount);
        if (errorCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
